/* Makefile */
TOP = mini_cpu_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f mini_cpu.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@! grep -q "TEST FAILED" $(LOG)
	@grep -q "TEST PASSED" $(LOG)

lint:
	verilator --lint-only --timing -f mini_cpu.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

/* mini_cpu.f */
+incdir+rtl
rtl/mini_cpu_pkg.sv
rtl/alu.sv
rtl/register_file.sv
rtl/datapath.sv
rtl/sequencer.sv
rtl/mini_cpu_top.sv
verification/tb_clock_gen.sv
verification/mini_cpu_assert.sv
verification/mini_cpu_tb.sv

/* rtl/alu.sv */
`timescale 1ns/1ps

`include "mini_cpu_config.svh"

module alu import mini_cpu_pkg::*; (
    input  logic  clk,
    input  logic  reset_n,
    input  data_t a,
    input  data_t b,
    input  logic  sub,
    input  logic  flags_we,
    output data_t result,
    output logic  carry,
    output logic  zero
);

    data_t                       b_eff;
    logic [`MINI_CPU_DATA_BITS:0] sum;

    // Subtract is a + ~b + 1, the carry-in doubles as the +1
    assign b_eff  = sub ? ~b : b;
    assign sum    = {1'b0, a} + {1'b0, b_eff} + {{`MINI_CPU_DATA_BITS{1'b0}}, sub};
    assign result = sum[`MINI_CPU_DATA_BITS-1:0];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            carry <= 1'b0;
            zero  <= 1'b0;
        end else if (flags_we) begin
            carry <= sum[`MINI_CPU_DATA_BITS];
            zero  <= (result == '0);
        end
    end

endmodule

/* rtl/datapath.sv */
`timescale 1ns/1ps

`include "mini_cpu_config.svh"

module datapath import mini_cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,

    input  ctrl_t    ctrl,
    input  addr_t    pc,

    input  data_t    mem_rd_data,
    output mem_req_t mem_req,

    output opcode_e  opcode,
    output data_t    jump_target,

    output reg_idx_t rd0_addr,
    output reg_idx_t rd1_addr,
    output reg_idx_t wr_addr,
    input  data_t    rd0_data,
    input  data_t    rd1_data,
    output data_t    wr_data,

    output data_t    alu_a,
    output data_t    alu_b,
    input  data_t    alu_result
);

    logic [2*`MINI_CPU_DATA_BITS-1:0] ir;
    data_t                            imm8;
    data_t                            data_lo;
    logic                             rr_form;

    // Instruction register, one byte per fetch cycle
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            ir <= {OP_NOP, 12'h000};
        end else begin
            if (ctrl.ir_hi_we) begin
                ir[2*`MINI_CPU_DATA_BITS-1:`MINI_CPU_DATA_BITS] <= mem_rd_data;
            end
            if (ctrl.ir_lo_we) begin
                ir[`MINI_CPU_DATA_BITS-1:0] <= mem_rd_data;
            end
        end
    end

    assign opcode      = opcode_e'(ir[15:12]);
    assign imm8        = ir[`MINI_CPU_DATA_BITS-1:0];
    assign jump_target = imm8;

    assign rr_form = (opcode == OP_ADD_RR) || (opcode == OP_SUB_RR);

    // Register indices
    assign rd0_addr = rr_form ? ir[7:4] : ir[11:8];
    assign rd1_addr = (ctrl.addr_sel == ADDR_DATA) ? reg_idx_t'(0) : ir[3:0];
    assign wr_addr  = ir[11:8];

    assign alu_a = rd0_data;
    assign alu_b = ctrl.alu_b_imm ? imm8 : rd1_data;

    always_comb begin
        case (ctrl.wb_sel)
            WB_IMM:  wr_data = imm8;
            WB_MEM:  wr_data = mem_rd_data;
            default: wr_data = alu_result;
        endcase
    end

    // The load address goes out in DECODE while the low byte is still on the bus
    assign data_lo = ctrl.ir_lo_we ? mem_rd_data : imm8;

    always_comb begin
        mem_req.rd_en   = ctrl.mem_rd;
        mem_req.wr_en   = ctrl.mem_wr;
        mem_req.wr_data = rd0_data;
        if (ctrl.addr_sel == ADDR_DATA) begin
            mem_req.addr = {rd1_data, data_lo};
        end else begin
            // Second instruction byte in FETCH_LO
            mem_req.addr = pc + addr_t'(ctrl.ir_hi_we);
        end
    end

endmodule

/* rtl/mini_cpu_config.svh */
`ifndef MINI_CPU_CONFIG_SVH
`define MINI_CPU_CONFIG_SVH

// Register and memory data width
`define MINI_CPU_DATA_BITS 8

// Byte address and program counter width
`define MINI_CPU_ADDR_BITS 16

// Register count, a 4-bit index in the instruction word
`define MINI_CPU_REG_COUNT 16

// First fetch address after reset
`define MINI_CPU_RESET_PC 16'h0000

`endif

/* rtl/mini_cpu_pkg.sv */
`include "mini_cpu_config.svh"

package mini_cpu_pkg;

    typedef logic [`MINI_CPU_DATA_BITS-1:0] data_t;
    typedef logic [`MINI_CPU_ADDR_BITS-1:0] addr_t;
    typedef logic [$clog2(`MINI_CPU_REG_COUNT)-1:0] reg_idx_t;

    // Instruction bits 15:12, codes 1 and 9 to 14 run as nop
    typedef enum logic [3:0] {
        OP_MOVI   = 4'd0,
        OP_LOAD   = 4'd2,
        OP_STORE  = 4'd3,
        OP_ADD_RR = 4'd4,
        OP_ADD_RI = 4'd5,
        OP_SUB_RR = 4'd6,
        OP_SUB_RI = 4'd7,
        OP_JNZ    = 4'd8,
        OP_NOP    = 4'd15
    } opcode_e;

    typedef enum logic [1:0] {
        FETCH_HI,
        FETCH_LO,
        DECODE,
        EXECUTE
    } exec_state_e;

    typedef enum logic {
        ADDR_PC,
        ADDR_DATA
    } addr_sel_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_IMM,
        WB_MEM
    } wb_sel_e;

    typedef struct packed {
        logic      ir_hi_we;
        logic      ir_lo_we;
        addr_sel_e addr_sel;
        logic      reg_we;
        wb_sel_e   wb_sel;
        logic      alu_b_imm;
        logic      alu_sub;
        logic      flags_we;
        logic      mem_rd;
        logic      mem_wr;
    } ctrl_t;

    typedef struct packed {
        logic  rd_en;
        logic  wr_en;
        addr_t addr;
        data_t wr_data;
    } mem_req_t;

endpackage

/* rtl/mini_cpu_top.sv */
`timescale 1ns/1ps

`include "mini_cpu_config.svh"

module mini_cpu_top import mini_cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    output mem_req_t mem_req,
    input  data_t    mem_rd_data
);

    ctrl_t    ctrl;
    addr_t    pc;
    opcode_e  opcode;
    data_t    jump_target;
    logic     zero;
    reg_idx_t rd0_addr;
    reg_idx_t rd1_addr;
    reg_idx_t wr_addr;
    data_t    rd0_data;
    data_t    rd1_data;
    data_t    wr_data;
    data_t    alu_a;
    data_t    alu_b;
    data_t    alu_result;

    sequencer u_sequencer (
        .clk         (clk),
        .reset_n     (reset_n),
        .opcode      (opcode),
        .jump_target (jump_target),
        .zero        (zero),
        .ctrl        (ctrl),
        .pc          (pc)
    );

    datapath u_datapath (
        .clk         (clk),
        .reset_n     (reset_n),
        .ctrl        (ctrl),
        .pc          (pc),
        .mem_rd_data (mem_rd_data),
        .mem_req     (mem_req),
        .opcode      (opcode),
        .jump_target (jump_target),
        .rd0_addr    (rd0_addr),
        .rd1_addr    (rd1_addr),
        .wr_addr     (wr_addr),
        .rd0_data    (rd0_data),
        .rd1_data    (rd1_data),
        .wr_data     (wr_data),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .alu_result  (alu_result)
    );

    register_file u_register_file (
        .clk      (clk),
        .reset_n  (reset_n),
        .rd0_addr (rd0_addr),
        .rd1_addr (rd1_addr),
        .rd0_data (rd0_data),
        .rd1_data (rd1_data),
        .we       (ctrl.reg_we),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    // No instruction reads carry yet
    alu u_alu (
        .clk      (clk),
        .reset_n  (reset_n),
        .a        (alu_a),
        .b        (alu_b),
        .sub      (ctrl.alu_sub),
        .flags_we (ctrl.flags_we),
        .result   (alu_result),
        .carry    (),
        .zero     (zero)
    );

endmodule

/* rtl/register_file.sv */
`timescale 1ns/1ps

`include "mini_cpu_config.svh"

module register_file import mini_cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  reg_idx_t rd0_addr,
    input  reg_idx_t rd1_addr,
    output data_t    rd0_data,
    output data_t    rd1_data,
    input  logic     we,
    input  reg_idx_t wr_addr,
    input  data_t    wr_data
);

    data_t regs [`MINI_CPU_REG_COUNT];

    assign rd0_data = regs[rd0_addr];
    assign rd1_data = regs[rd1_addr];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < `MINI_CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

/* rtl/sequencer.sv */
`timescale 1ns/1ps

`include "mini_cpu_config.svh"

module sequencer import mini_cpu_pkg::*; (
    input  logic    clk,
    input  logic    reset_n,
    input  opcode_e opcode,
    input  data_t   jump_target,
    input  logic    zero,
    output ctrl_t   ctrl,
    output addr_t   pc
);

    exec_state_e state;
    exec_state_e state_next;
    logic        boot;
    addr_t       pc_next;

    // Idle EXECUTE slot right after reset
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            boot <= 1'b1;
        end else begin
            boot <= 1'b0;
        end
    end

    always_comb begin
        case (state)
            FETCH_HI: state_next = FETCH_LO;
            FETCH_LO: state_next = DECODE;
            DECODE:   state_next = EXECUTE;
            default:  state_next = FETCH_HI;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= EXECUTE;
        end else begin
            state <= state_next;
        end
    end

    // Branch rule, zero flag is the one left by the last arithmetic op
    assign pc_next = (opcode == OP_JNZ && !zero) ? addr_t'(jump_target)
                                                 : pc + addr_t'(2);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc <= `MINI_CPU_RESET_PC;
        end else if (state == EXECUTE && !boot) begin
            pc <= pc_next;
        end
    end

    always_comb begin
        ctrl = '0;
        case (state)
            FETCH_HI: begin
                ctrl.mem_rd = 1'b1;
            end
            FETCH_LO: begin
                ctrl.ir_hi_we = 1'b1;
                ctrl.mem_rd   = 1'b1;
            end
            DECODE: begin
                ctrl.ir_lo_we = 1'b1;
                if (opcode == OP_LOAD) begin
                    ctrl.mem_rd   = 1'b1;
                    ctrl.addr_sel = ADDR_DATA;
                end
            end
            EXECUTE: begin
                case (opcode)
                    OP_MOVI: begin
                        ctrl.reg_we = 1'b1;
                        ctrl.wb_sel = WB_IMM;
                    end
                    OP_LOAD: begin
                        ctrl.reg_we = 1'b1;
                        ctrl.wb_sel = WB_MEM;
                    end
                    OP_STORE: begin
                        ctrl.mem_wr   = 1'b1;
                        ctrl.addr_sel = ADDR_DATA;
                    end
                    OP_ADD_RR, OP_ADD_RI, OP_SUB_RR, OP_SUB_RI: begin
                        ctrl.reg_we    = 1'b1;
                        ctrl.wb_sel    = WB_ALU;
                        ctrl.flags_we  = 1'b1;
                        ctrl.alu_b_imm = (opcode == OP_ADD_RI) || (opcode == OP_SUB_RI);
                        ctrl.alu_sub   = (opcode == OP_SUB_RR) || (opcode == OP_SUB_RI);
                    end
                    // jnz only moves the pc, everything else is a nop
                    default: begin
                    end
                endcase
            end
            default: begin
            end
        endcase
    end

endmodule

/* verification/mini_cpu_assert.sv */
`timescale 1ns/1ps

module mini_cpu_assert import mini_cpu_pkg::*; (
    input logic     clk,
    input logic     reset_n,
    input mem_req_t mem_req
);

    // Read and write never share a cycle
    assert property (@(posedge clk) disable iff (!reset_n)
        !(mem_req.rd_en && mem_req.wr_en))
        else $error("read and write enables high together");

    assert property (@(posedge clk) disable iff (!reset_n)
        mem_req.wr_en |=> !mem_req.wr_en)
        else $error("write enable held longer than one cycle");

    // Synchronous reset, so the enables drop one cycle into reset
    assert property (@(posedge clk)
        !reset_n |=> (!mem_req.rd_en && !mem_req.wr_en))
        else $error("memory enable high during reset");

endmodule

bind mini_cpu_top mini_cpu_assert u_assert (
    .clk     (clk),
    .reset_n (reset_n),
    .mem_req (mem_req)
);

/* verification/mini_cpu_tb.sv */
`timescale 1ns/1ps

`include "mini_cpu_config.svh"

module mini_cpu_tb import mini_cpu_pkg::*; ();

    localparam int N_ENTRIES  = 4;
    localparam int MAX_INSTR  = 16;
    localparam int MAX_STORES = 8;

    logic     clk;
    logic     reset_n;
    logic     restart;
    mem_req_t mem_req;
    data_t    mem_rd_data;

    // Program table
    logic [15:0] prog        [N_ENTRIES][MAX_INSTR];
    int          prog_len    [N_ENTRIES];
    int          dyn_instr   [N_ENTRIES];
    addr_t       preset_addr [N_ENTRIES];
    data_t       preset_data [N_ENTRIES];
    addr_t       exp_addr    [N_ENTRIES][MAX_STORES];
    data_t       exp_data    [N_ENTRIES][MAX_STORES];
    int          exp_count   [N_ENTRIES];

    data_t       mem [addr_t];
    addr_t       wr_addr_q [$];
    data_t       wr_data_q [$];
    addr_t       read_q [$];
    logic        rd_pending;
    addr_t       rd_addr_q;
    logic [31:0] rng;
    int          cycles;
    int          limit;
    int          value_errors;
    int          other_errors;

    tb_clock_gen u_clock_gen (
        .restart (restart),
        .clk     (clk),
        .reset_n (reset_n)
    );

    mini_cpu_top DUT (
        .clk         (clk),
        .reset_n     (reset_n),
        .mem_req     (mem_req),
        .mem_rd_data (mem_rd_data)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic data_t next_operand();
        rng = xorshift(rng);
        return rng[7:0];
    endfunction

    function automatic logic [15:0] encode(opcode_e op, logic [3:0] r, logic [7:0] lo);
        return {op, r, lo};
    endfunction

    // Unwritten bytes
    function automatic data_t fill_byte(addr_t a);
        return a[15:8] ^ {a[6:0], a[7]} ^ 8'h3c;
    endfunction

    function automatic data_t read_byte(addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return fill_byte(a);
    endfunction

    task automatic add_instr(int e, logic [15:0] word);
        prog[e][prog_len[e]] = word;
        prog_len[e] = prog_len[e] + 1;
    endtask

    task automatic add_store(int e, addr_t a, data_t d);
        exp_addr[e][exp_count[e]] = a;
        exp_data[e][exp_count[e]] = d;
        exp_count[e] = exp_count[e] + 1;
    endtask

    task automatic build_table();
        data_t a;
        data_t b;
        data_t c;
        data_t d;
        data_t k;
        for (int e = 0; e < N_ENTRIES; e++) begin
            prog_len[e]    = 0;
            exp_count[e]   = 0;
            preset_addr[e] = 16'hf000;
            preset_data[e] = 8'h00;
        end
        // mov then store to a nonzero page
        k = next_operand();
        add_instr(0, encode(OP_MOVI, 4'd0, 8'h12));
        add_instr(0, encode(OP_MOVI, 4'd3, k));
        add_instr(0, encode(OP_STORE, 4'd3, 8'h34));
        add_store(0, 16'h1234, k);
        dyn_instr[0] = 3;
        // Register and immediate arithmetic, register-register results land above r7
        a = next_operand();
        b = next_operand();
        c = next_operand();
        add_instr(1, encode(OP_MOVI, 4'd1, a));
        add_instr(1, encode(OP_MOVI, 4'd2, b));
        add_instr(1, encode(OP_ADD_RR, 4'd12, 8'h12));
        add_instr(1, encode(OP_SUB_RR, 4'd13, 8'h12));
        add_instr(1, encode(OP_ADD_RI, 4'd1, c));
        add_instr(1, encode(OP_SUB_RI, 4'd2, c));
        add_instr(1, encode(OP_MOVI, 4'd0, 8'h20));
        add_instr(1, encode(OP_STORE, 4'd12, 8'h00));
        add_instr(1, encode(OP_STORE, 4'd13, 8'h01));
        add_instr(1, encode(OP_STORE, 4'd1, 8'h02));
        add_instr(1, encode(OP_STORE, 4'd2, 8'h03));
        add_store(1, 16'h2000, data_t'(a + b));
        add_store(1, 16'h2001, data_t'(a - b));
        add_store(1, 16'h2002, data_t'(a + c));
        add_store(1, 16'h2003, data_t'(b - c));
        dyn_instr[1] = 11;
        // Load a preset byte, add, store
        d = next_operand();
        k = next_operand();
        preset_addr[2] = 16'h3010;
        preset_data[2] = d;
        add_instr(2, encode(OP_MOVI, 4'd0, 8'h30));
        add_instr(2, encode(OP_LOAD, 4'd6, 8'h10));
        add_instr(2, encode(OP_ADD_RI, 4'd6, k));
        add_instr(2, encode(OP_STORE, 4'd6, 8'h11));
        add_store(2, 16'h3011, data_t'(d + k));
        dyn_instr[2] = 4;
        // Countdown loop, jnz back to the subi at address 4
        add_instr(3, encode(OP_MOVI, 4'd0, 8'h40));
        add_instr(3, encode(OP_MOVI, 4'd1, 8'd3));
        add_instr(3, encode(OP_SUB_RI, 4'd1, 8'd1));
        add_instr(3, encode(OP_STORE, 4'd1, 8'h00));
        add_instr(3, encode(OP_JNZ, 4'd0, 8'h04));
        add_instr(3, encode(OP_MOVI, 4'd7, 8'ha5));
        add_instr(3, encode(OP_STORE, 4'd7, 8'h01));
        for (int n = 2; n >= 0; n--) begin
            add_store(3, 16'h4000, data_t'(n));
        end
        add_store(3, 16'h4001, 8'ha5);
        dyn_instr[3] = 13;
    endtask

    // Memory model, sampled at the rising edge before the DUT updates
    always @(posedge clk) begin
        rd_pending <= reset_n && mem_req.rd_en;
        rd_addr_q  <= mem_req.addr;
        if (reset_n && mem_req.wr_en) begin
            wr_addr_q.push_back(mem_req.addr);
            wr_data_q.push_back(mem_req.wr_data);
            mem[mem_req.addr] = mem_req.wr_data;
        end
        if (reset_n && mem_req.rd_en) begin
            read_q.push_back(mem_req.addr);
        end
    end

    always @(negedge clk) begin
        mem_rd_data <= rd_pending ? read_byte(rd_addr_q) : 8'h00;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: expected stores not seen within %0d cycles", limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int total;
        mem_rd_data  = 8'h00;
        restart      = 1'b0;
        rd_pending   = 1'b0;
        rd_addr_q    = '0;
        cycles       = 0;
        value_errors = 0;
        other_errors = 0;
        rng          = 32'h81cf5a84;
        build_table();
        total = 0;
        for (int e = 0; e < N_ENTRIES; e++) begin
            total = total + dyn_instr[e];
        end
        limit = (4 * total + 16 * N_ENTRIES) * 2;

        for (int e = 0; e < N_ENTRIES; e++) begin
            @(negedge clk);
            restart = 1'b1;
            @(negedge clk);
            restart = 1'b0;
            mem.delete();
            wr_addr_q.delete();
            wr_data_q.delete();
            read_q.delete();
            for (int i = 0; i < prog_len[e]; i++) begin
                mem[addr_t'(2 * i)]     = prog[e][i][15:8];
                mem[addr_t'(2 * i + 1)] = prog[e][i][7:0];
            end
            mem[preset_addr[e]] = preset_data[e];
            while (wr_addr_q.size() < exp_count[e]) begin
                @(negedge clk);
            end
            for (int s = 0; s < exp_count[e]; s++) begin
                assert (wr_addr_q[s] == exp_addr[e][s]) else begin
                    value_errors++;
                    $display("Fail entry %0d store %0d: mem_req.addr got %h expected %h",
                             e, s, wr_addr_q[s], exp_addr[e][s]);
                end
                assert (wr_data_q[s] == exp_data[e][s]) else begin
                    value_errors++;
                    $display("Fail entry %0d store %0d: mem_req.wr_data got %h expected %h",
                             e, s, wr_data_q[s], exp_data[e][s]);
                end
            end
            // Straight-line fetches start at 0 and step by one byte
            if (e == 0) begin
                assert (read_q.size() >= 6) else begin
                    other_errors++;
                    $display("Too few fetches seen before the first store");
                end
                for (int r = 0; r < 6 && r < read_q.size(); r++) begin
                    assert (read_q[r] == addr_t'(r)) else begin
                        value_errors++;
                        $display("Fail fetch %0d: mem_req.addr got %h expected %h",
                                 r, read_q[r], addr_t'(r));
                    end
                end
            end
        end

        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    input  logic restart,
    output logic clk,
    output logic reset_n
);

    int unsigned hold;

    initial begin
        clk     = 1'b0;
        reset_n = 1'b0;
        hold    = 16;
    end

    always #50 clk = ~clk;

    // Reset low for 16 cycles at start and after each restart pulse
    always @(posedge clk) begin
        if (restart) begin
            hold    <= 16;
            reset_n <= 1'b0;
        end else if (hold > 1) begin
            hold <= hold - 1;
        end else begin
            hold    <= 0;
            reset_n <= 1'b1;
        end
    end

endmodule
